// File: mem_sched_top.f
+incdir+verilog
verilog/sched_pkg.sv
verilog/req_fifo.sv
verilog/drain_mode_ctrl.sv
verilog/burst_scheduler.sv
verilog/cmd_issue.sv
verilog/mem_sched_top.sv
verif/mem_sched_tb.sv

// File: verif/mem_sched_tb.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module mem_sched_tb;
   import sched_pkg::*;

   localparam int NUM_RD      = `SCHED_NUM_RD;
   localparam int NUM_Q       = `SCHED_NUM_Q;
   localparam int CLK_PERIOD  = 40;
   localparam int HOLD_CYCLES = 12;
   localparam int RAND_REQS   = 60;
   localparam int TOTAL_REQ   = NUM_RD + 14 + NUM_Q + RAND_REQS;  // all four loading phases
   localparam int CYC_PER_REQ = 12;                              // lone burst plus back-pressure
   localparam int WATCHDOG_NS = (TOTAL_REQ * CYC_PER_REQ + HOLD_CYCLES + 40) * CLK_PERIOD;

   localparam q_mask_t WR_QUEUES = 7'b111_0000;  // write queues on mask bits 4..6

   logic                     clk;
   logic                     rst_n;
   logic [`SCHED_NUM_RD-1:0] rd_push;
   req_t [`SCHED_NUM_RD-1:0] rd_req;
   logic [`SCHED_NUM_WR-1:0] wr_push;
   req_t [`SCHED_NUM_WR-1:0] wr_req;
   logic                     ready_i;
   q_mask_t                  full_o;
   logic                     burst_req_o;
   logic                     cmd_valid_o;
   cmd_t                     cmd_o;

   req_t   sb [NUM_Q][$];    // outstanding requests per queue, oldest first
   q_idx_t first_log [$];    // queue of each burst opener
   burst_t cur_burst;        // burst of the last opener
   logic   cur_wr;
   bit     drain_watch;      // write drain window open
   bit     rd_reopen;        // next opener must be a read
   int     errors;
   int     err_at_start;
   int     tests_run;
   int     tests_failed;
   int     pushed;
   int     issued;
   string  cur_test = "reset";

   mem_sched_top dut_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .rd_push_i   (rd_push),
      .rd_req_i    (rd_req),
      .wr_push_i   (wr_push),
      .wr_req_i    (wr_req),
      .ready_i     (ready_i),
      .full_o      (full_o),
      .burst_req_o (burst_req_o),
      .cmd_valid_o (cmd_valid_o),
      .cmd_o       (cmd_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // bursts open only on a granted request
   a_first_after_req: assert property (@(posedge clk) disable iff (rst_n)
         (cmd_valid_o && cmd_o.first) |-> $past(burst_req_o && ready_i))
      else begin
         errors++;
         $display("%s: burst opened without burst_req_o and ready_i both high", cur_test);
      end

   // direction follows the queue number
   a_wr_flag: assert property (@(posedge clk) disable iff (rst_n)
         cmd_valid_o |-> (cmd_o.wr == WR_QUEUES[cmd_o.qidx]))
      else begin
         errors++;
         $display("ERROR %s: expected wr %0b, actual %0b", cur_test,
                  WR_QUEUES[cmd_o.qidx], cmd_o.wr);
      end

   // idle with ready low stays idle
   a_hold: assert property (@(posedge clk) disable iff (rst_n)
         (!ready_i && !cmd_valid_o) |=> !cmd_valid_o)
      else begin
         errors++;
         $display("%s: command issued while ready_i held low", cur_test);
      end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired in test %s, requests still outstanding", cur_test);
      $display("Testbench failed");
      $finish;
   end

   function automatic int wr_outstanding();
      int n;
      n = 0;
      for (int q = NUM_RD; q < NUM_Q; q++) n += sb[q].size();
      return n;
   endfunction

   function automatic int outstanding();
      int n;
      n = wr_outstanding();
      for (int q = 0; q < NUM_RD; q++) n += sb[q].size();
      return n;
   endfunction

   function automatic burst_t pick_burst();
      return burst_t'(8'h3a + $urandom_range(2));  // small set so heads match
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #2;
      rd_push = '0;  // push strobes last one cycle
      wr_push = '0;
   endtask

   // queue a request for the next edge, skipped when full
   task automatic load(input int q, input burst_t b, output bit ok);
      req_t r;
      r.addr = addr_t'($urandom);
      r.addr[`SCHED_ADDR_W-1 -: `SCHED_BURST_W] = b;  // burst id in the top bits
      r.id = req_id_t'($urandom);
      ok = !full_o[q];
      if (ok) begin
         if (q < NUM_RD) begin
            rd_push[q] = 1'b1;
            rd_req[q]  = r;
         end else begin
            wr_push[q-NUM_RD] = 1'b1;
            wr_req[q-NUM_RD]  = r;
         end
         sb[q].push_back(r);
         pushed++;
      end
   endtask

   task automatic wait_drained();
      while (outstanding() != 0) @(negedge clk);
      repeat (3) next_cycle();  // scheduler back to idle
   endtask

   task automatic start_test(input string name);
      cur_test     = name;
      err_at_start = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors != err_at_start) tests_failed++;
      $display("test %s: %s", cur_test, (errors == err_at_start) ? "ok" : "FAIL");
   endtask

   task automatic check_cmd(input cmd_t c);
      req_t   exp;
      burst_t b;
      int     wr_left;
      b = c.addr[`SCHED_ADDR_W-1 -: `SCHED_BURST_W];
      issued++;
      if (c.first) first_log.push_back(c.qidx);
      assert (sb[c.qidx].size() > 0) else begin
         errors++;
         $display("%s: command from queue %0d that has nothing outstanding", cur_test, c.qidx);
         return;
      end
      exp = sb[c.qidx].pop_front();
      assert (c.addr == exp.addr && c.id == exp.id) else begin
         errors++;
         $display("ERROR %s: expected %h, actual %h", cur_test, exp, {c.addr, c.id});
      end
      if (c.first) begin
         cur_burst = b;
         cur_wr    = c.wr;
      end else begin
         assert (b == cur_burst && c.wr == cur_wr) else begin
            errors++;
            $display("ERROR %s: expected burst %h wr %0b, actual burst %h wr %0b",
                     cur_test, cur_burst, cur_wr, b, c.wr);
         end
      end
      if (c.first && rd_reopen) begin
         assert (!c.wr) else begin
            errors++;
            $display("ERROR %s: expected wr 0, actual wr %0b on the first burst after drain",
                     cur_test, c.wr);
         end
         rd_reopen = 1'b0;
      end
      wr_left = wr_outstanding();
      if (drain_watch) begin
         assert (c.wr || wr_left <= `SCHED_WR_LO) else begin
            errors++;
            $display("ERROR %s: expected wr 1, actual wr 0 with %0d writes left",
                     cur_test, wr_left);
         end
         if (wr_left <= `SCHED_WR_LO) begin
            drain_watch = 1'b0;  // low watermark reached
            rd_reopen   = 1'b1;  // reads waiting, mode drops back
         end
      end
   endtask

   always @(negedge clk) begin
      if (!rst_n && cmd_valid_o) check_cmd(cmd_o);  // mid-cycle, outputs settled
   end

   initial begin
      int unused_seed;
      bit ok;
      int got;
      int done;
      unused_seed = $urandom(32'hf7a3);
      rd_push = '0;
      rd_req  = '0;
      wr_push = '0;
      wr_req  = '0;
      ready_i = 1'b0;
      rst_n   = 1'b1;  // reset is active high
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b0;

      start_test("reset");
      @(negedge clk);
      assert (!cmd_valid_o && !burst_req_o && full_o == '0) else begin
         errors++;
         $display("ERROR %s: expected %h, actual %h", cur_test, 9'h0,
                  {cmd_valid_o, burst_req_o, full_o});
      end
      end_test();
      next_cycle();

      start_test("round_robin");
      ready_i = 1'b1;
      first_log.delete();
      for (int q = 0; q < NUM_RD; q++) load(q, burst_t'(8'h10 * (q + 1)), ok);
      next_cycle();
      wait_drained();
      assert (first_log.size() == NUM_RD) else begin
         errors++;
         $display("ERROR %s: expected %0d, actual %0d", cur_test, NUM_RD, first_log.size());
      end
      for (int i = 0; i < first_log.size() && i < NUM_RD; i++) begin
         assert (first_log[i] == q_idx_t'(i)) else begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", cur_test, i, first_log[i]);
         end
      end
      end_test();

      start_test("write_drain");
      ready_i = 1'b0;
      for (int r = 0; r < 2; r++) begin
         for (int q = 0; q < NUM_RD; q++) load(q, pick_burst(), ok);
         next_cycle();
      end
      while (wr_outstanding() < `SCHED_WR_HI) begin
         for (int q = NUM_RD; q < NUM_Q; q++) begin
            if (wr_outstanding() < `SCHED_WR_HI) load(q, pick_burst(), ok);
         end
         next_cycle();
      end
      next_cycle();  // mode register takes the watermark
      drain_watch = 1'b1;
      ready_i     = 1'b1;
      wait_drained();
      end_test();

      start_test("ready_hold");
      ready_i = 1'b0;
      got     = issued;
      for (int q = 0; q < NUM_Q; q++) load(q, pick_burst(), ok);
      next_cycle();
      repeat (HOLD_CYCLES) next_cycle();
      assert (issued == got) else begin
         errors++;
         $display("ERROR %s: expected %0d, actual %0d", cur_test, got, issued);
      end
      ready_i = 1'b1;
      wait_drained();
      end_test();

      start_test("random");
      done = 0;
      while (done < RAND_REQS) begin
         ready_i = ($urandom_range(3) != 0);  // ready about three cycles in four
         load($urandom_range(NUM_Q - 1), pick_burst(), ok);
         if (ok) done++;
         next_cycle();
      end
      ready_i = 1'b1;
      wait_drained();
      end_test();

      start_test("final");
      assert (issued == pushed) else begin
         errors++;
         $display("ERROR %s: expected %0d, actual %0d", cur_test, pushed, issued);
      end
      end_test();

      $display("tests run %0d, tests failed %0d, check errors %0d, requests %0d",
               tests_run, tests_failed, errors, pushed);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: verilog/burst_scheduler.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module burst_scheduler (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  ready_i,
   input  logic                                  write_mode_i,
   input  sched_pkg::q_mask_t                    empty_i,
   input  sched_pkg::req_t [`SCHED_NUM_Q-1:0]    heads_i,
   output sched_pkg::q_mask_t                    pop_o,
   output logic                                  first_o,
   output logic                                  burst_req_o
);
   import sched_pkg::*;

   localparam int RD_PTR_W = (`SCHED_NUM_RD > 1) ? $clog2(`SCHED_NUM_RD) : 1;
   localparam int WR_PTR_W = (`SCHED_NUM_WR > 1) ? $clog2(`SCHED_NUM_WR) : 1;

   // direction masks over the queue vector
   localparam q_mask_t RD_MASK = {{`SCHED_NUM_WR{1'b0}}, {`SCHED_NUM_RD{1'b1}}};
   localparam q_mask_t WR_MASK = ~RD_MASK;

   sched_state_e        state;
   sched_state_e        state_nxt;
   logic [RD_PTR_W-1:0] rd_ptr;       // next read queue in round robin
   logic [WR_PTR_W-1:0] wr_ptr;       // next write queue, local index
   burst_t              burst_q;      // id of the burst being drained
   q_mask_t             mode_mask;    // queues of the current mode
   q_mask_t             dir_mask;     // queues of the burst in progress
   q_mask_t             avail;        // non-empty queues of current mode
   q_mask_t             hits;         // heads matching burst_q
   q_idx_t              ptr_q;        // round robin pick as queue number
   q_idx_t              grant_idx;    // queue that opens the burst
   burst_t              grant_burst;  // its burst id
   logic                rd_adv;       // step read pointer
   logic                wr_adv;       // step write pointer

   function automatic burst_t burst_of(input req_t r);
      return r.addr[`SCHED_ADDR_W-1 -: `SCHED_BURST_W];  // top address bits
   endfunction

   // lowest set bit, caller checks the mask is not zero
   function automatic q_idx_t lowest_idx(input q_mask_t m);
      q_idx_t idx;
      idx = '0;
      for (int i = `SCHED_NUM_Q-1; i >= 0; i--) begin
         if (m[i]) begin
            idx = q_idx_t'(i);
         end
      end
      return idx;
   endfunction

   function automatic q_mask_t onehot(input q_idx_t idx);
      return q_mask_t'(1) << idx;
   endfunction

   assign mode_mask = write_mode_i ? WR_MASK : RD_MASK;  // only looked at outside a burst
   assign avail     = ~empty_i & mode_mask;

   // write pointer is local, offset past the read queues
   assign ptr_q = write_mode_i ? q_idx_t'(`SCHED_NUM_RD) + q_idx_t'(wr_ptr)
                               : q_idx_t'(rd_ptr);

   // pointer queue if it has work, else lowest busy one
   assign grant_idx   = avail[ptr_q] ? ptr_q : lowest_idx(avail);
   assign grant_burst = burst_of(heads_i[grant_idx]);

   always_comb begin
      case (state)
         RD_BURST: dir_mask = RD_MASK;
         WR_BURST: dir_mask = WR_MASK;
         default:  dir_mask = '0;     // no hits outside a burst
      endcase
   end

   always_comb begin
      for (int i = 0; i < `SCHED_NUM_Q; i++) begin
         hits[i] = dir_mask[i] && !empty_i[i] && (burst_of(heads_i[i]) == burst_q);
      end
   end

   always_comb begin
      state_nxt   = state;
      pop_o       = '0;
      first_o     = 1'b0;
      burst_req_o = 1'b0;
      rd_adv      = 1'b0;
      wr_adv      = 1'b0;
      case (state)
         IDLE, FINISH: begin
            state_nxt = (|avail) ? WAITING : IDLE;  // mode sampled here
         end
         WAITING: begin
            burst_req_o = 1'b1;
            if (!(|avail)) begin
               state_nxt = IDLE;  // mode flipped to an empty side
            end else if (ready_i) begin
               pop_o     = onehot(grant_idx);
               first_o   = 1'b1;  // opens the burst
               state_nxt = write_mode_i ? WR_BURST : RD_BURST;
            end
         end
         RD_BURST, WR_BURST: begin
            // ready_i is ignored once a burst runs
            if (|hits) begin
               pop_o = onehot(lowest_idx(hits));  // one pop per cycle
            end else begin
               state_nxt = FINISH;
               rd_adv    = (state == RD_BURST);
               wr_adv    = (state == WR_BURST);
            end
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_n) begin
         state  <= IDLE;
         rd_ptr <= '0;
         wr_ptr <= '0;
      end else begin
         state <= state_nxt;
         if (rd_adv) begin
            rd_ptr <= (rd_ptr == RD_PTR_W'(`SCHED_NUM_RD-1)) ? '0 : rd_ptr + 1'b1;
         end
         if (wr_adv) begin
            wr_ptr <= (wr_ptr == WR_PTR_W'(`SCHED_NUM_WR-1)) ? '0 : wr_ptr + 1'b1;
         end
      end
   end

   // burst id taken with the opening pop
   always_ff @(posedge clk) begin
      if (first_o) begin
         burst_q <= grant_burst;
      end
   end

endmodule

// File: verilog/cmd_issue.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module cmd_issue (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  sched_pkg::q_mask_t                    pop_i,
   input  logic                                  first_i,
   input  sched_pkg::req_t [`SCHED_NUM_Q-1:0]    heads_i,
   output logic                                  cmd_valid_o,
   output sched_pkg::cmd_t                       cmd_o
);
   import sched_pkg::*;

   q_idx_t sel_idx;   // popped queue number
   req_t   sel_req;   // its head before the pop lands
   cmd_t   cmd_nxt;

   // one-hot to binary, pop has at most one bit
   always_comb begin
      sel_idx = '0;
      for (int i = 0; i < `SCHED_NUM_Q; i++) begin
         if (pop_i[i]) begin
            sel_idx = sel_idx | q_idx_t'(i);
         end
      end
   end

   assign sel_req = heads_i[sel_idx];

   always_comb begin
      cmd_nxt.wr    = (sel_idx >= q_idx_t'(`SCHED_NUM_RD));  // write queues sit above reads
      cmd_nxt.first = first_i;
      cmd_nxt.qidx  = sel_idx;
      cmd_nxt.addr  = sel_req.addr;
      cmd_nxt.id    = sel_req.id;
   end

   always_ff @(posedge clk) begin
      if (rst_n) begin
         cmd_valid_o <= 1'b0;
      end else begin
         cmd_valid_o <= |pop_i;  // one cycle after each pop
      end
   end

   always_ff @(posedge clk) begin
      if (|pop_i) begin
         cmd_o <= cmd_nxt;
      end
   end

endmodule

// File: verilog/drain_mode_ctrl.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module drain_mode_ctrl (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic [`SCHED_NUM_WR-1:0][`SCHED_CNT_W-1:0]    wr_count_i,
   input  logic [`SCHED_NUM_RD-1:0]                      rd_empty_i,
   input  logic [`SCHED_NUM_WR-1:0]                      wr_empty_i,
   output logic                                          write_mode_o
);

   localparam int SUM_W = $clog2(`SCHED_NUM_WR * `SCHED_FIFO_DEPTH + 1);

   logic [SUM_W-1:0] wr_total;   // writes waiting over all queues
   logic             rd_idle;    // no read pending
   logic             wr_idle;    // no write pending
   logic             set_wr;
   logic             clr_wr;

   always_comb begin
      wr_total = '0;
      for (int i = 0; i < `SCHED_NUM_WR; i++) begin
         wr_total = wr_total + SUM_W'(wr_count_i[i]);
      end
   end

   assign rd_idle = &rd_empty_i;
   assign wr_idle = &wr_empty_i;

   // high watermark, or nothing else to do
   assign set_wr = (wr_total >= SUM_W'(`SCHED_WR_HI)) || (rd_idle && !wr_idle);
   // drained low enough and reads are waiting
   assign clr_wr = (wr_total <= SUM_W'(`SCHED_WR_LO)) && !rd_idle;

   // hysteresis between the two watermarks
   always_ff @(posedge clk) begin
      if (rst_n) begin
         write_mode_o <= 1'b0;  // start in read drain
      end else if (set_wr) begin
         write_mode_o <= 1'b1;
      end else if (clr_wr) begin
         write_mode_o <= 1'b0;
      end
   end

endmodule

// File: verilog/mem_sched_top.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module mem_sched_top (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic [`SCHED_NUM_RD-1:0]              rd_push_i,
   input  sched_pkg::req_t [`SCHED_NUM_RD-1:0]   rd_req_i,
   input  logic [`SCHED_NUM_WR-1:0]              wr_push_i,
   input  sched_pkg::req_t [`SCHED_NUM_WR-1:0]   wr_req_i,
   input  logic                                  ready_i,
   output sched_pkg::q_mask_t                    full_o,
   output logic                                  burst_req_o,
   output logic                                  cmd_valid_o,
   output sched_pkg::cmd_t                       cmd_o
);
   import sched_pkg::*;

   q_mask_t                                     push;      // reads low, writes high
   req_t [`SCHED_NUM_Q-1:0]                     push_req;
   req_t [`SCHED_NUM_Q-1:0]                     heads;     // show-ahead heads
   q_mask_t                                     empty;
   q_mask_t                                     pop;       // from scheduler
   logic [`SCHED_NUM_Q-1:0][`SCHED_CNT_W-1:0]   count;
   logic                                        write_mode;
   logic                                        first;     // opening pop

   assign push     = {wr_push_i, rd_push_i};
   assign push_req = {wr_req_i, rd_req_i};

   for (genvar q = 0; q < `SCHED_NUM_Q; q++) begin : g_queue
      req_fifo #(
         .DEPTH   (`SCHED_FIFO_DEPTH)
      ) u_fifo (
         .clk     (clk),
         .rst_n   (rst_n),
         .push_i  (push[q]),
         .req_i   (push_req[q]),
         .pop_i   (pop[q]),
         .head_o  (heads[q]),
         .empty_o (empty[q]),
         .full_o  (full_o[q]),
         .count_o (count[q])
      );
   end

   drain_mode_ctrl u_mode (
      .clk          (clk),
      .rst_n        (rst_n),
      .wr_count_i   (count[`SCHED_NUM_Q-1:`SCHED_NUM_RD]),  // write queues only
      .rd_empty_i   (empty[`SCHED_NUM_RD-1:0]),
      .wr_empty_i   (empty[`SCHED_NUM_Q-1:`SCHED_NUM_RD]),
      .write_mode_o (write_mode)
   );

   burst_scheduler u_sched (
      .clk          (clk),
      .rst_n        (rst_n),
      .ready_i      (ready_i),
      .write_mode_i (write_mode),
      .empty_i      (empty),
      .heads_i      (heads),
      .pop_o        (pop),
      .first_o      (first),
      .burst_req_o  (burst_req_o)
   );

   cmd_issue u_issue (
      .clk          (clk),
      .rst_n        (rst_n),
      .pop_i        (pop),
      .first_i      (first),
      .heads_i      (heads),
      .cmd_valid_o  (cmd_valid_o),
      .cmd_o        (cmd_o)
   );

endmodule

// File: verilog/req_fifo.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module req_fifo #(
   parameter int DEPTH = `SCHED_FIFO_DEPTH
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         push_i,
   input  sched_pkg::req_t              req_i,
   input  logic                         pop_i,
   output sched_pkg::req_t              head_o,
   output logic                         empty_o,
   output logic                         full_o,
   output logic [$clog2(DEPTH+1)-1:0]   count_o
);
   import sched_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   req_t             mem [DEPTH];  // entry storage
   logic [PTR_W-1:0] rd_ptr;       // head slot
   logic [PTR_W-1:0] wr_ptr;       // next free slot
   logic             do_push;
   logic             do_pop;

   assign empty_o = (count_o == '0);
   assign full_o  = (count_o == DEPTH);
   assign do_push = push_i && !full_o;   // push on full dropped
   assign do_pop  = pop_i && !empty_o;   // pop on empty dropped
   assign head_o  = mem[rd_ptr];         // show-ahead, no read strobe

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= req_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_n) begin
         rd_ptr  <= '0;
         wr_ptr  <= '0;
         count_o <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;  // wrap for any depth
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_o <= count_o + 1'b1;
            2'b01:   count_o <= count_o - 1'b1;
            default: count_o <= count_o;  // both or neither
         endcase
      end
   end

endmodule

// File: verilog/sched_defines.svh
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

// queue counts
`define SCHED_NUM_RD      4                                // read queues, mask bits 0..3
`define SCHED_NUM_WR      3                                // write queues, mask bits 4..6
`define SCHED_NUM_Q       (`SCHED_NUM_RD + `SCHED_NUM_WR)  // all queues

// queue storage
`define SCHED_FIFO_DEPTH  4                                // entries per queue
`define SCHED_CNT_W       ($clog2(`SCHED_FIFO_DEPTH + 1))  // occupancy 0..depth

// request fields
`define SCHED_ADDR_W      16                               // request address
`define SCHED_BURST_W     8                                // burst id, top address bits
`define SCHED_ID_W        4                                // client id
`define SCHED_QIDX_W      ($clog2(`SCHED_NUM_Q))           // queue index

// write drain watermarks, total write occupancy
`define SCHED_WR_HI       6                                // at or above, force write drain
`define SCHED_WR_LO       2                                // at or below, back to reads

`endif

// File: verilog/sched_pkg.sv
`include "sched_defines.svh"

package sched_pkg;

   typedef logic [`SCHED_ADDR_W-1:0]  addr_t;    // request address
   typedef logic [`SCHED_BURST_W-1:0] burst_t;   // upper address bits
   typedef logic [`SCHED_ID_W-1:0]    req_id_t;  // client tag
   typedef logic [`SCHED_NUM_Q-1:0]   q_mask_t;  // one bit per queue, reads low
   typedef logic [`SCHED_QIDX_W-1:0]  q_idx_t;   // absolute queue number

   // what a client pushes
   typedef struct packed {
      addr_t   addr;
      req_id_t id;
   } req_t;

   // what leaves toward the device
   typedef struct packed {
      logic    wr;     // 1 for write queues
      logic    first;  // opens a burst
      q_idx_t  qidx;   // source queue
      addr_t   addr;
      req_id_t id;
   } cmd_t;

   typedef enum logic [2:0] {
      IDLE,
      WAITING,   // burst_req_o up, waiting on ready_i
      RD_BURST,
      WR_BURST,
      FINISH     // burst done, pointer advanced
   } sched_state_e;

endpackage
